// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_exec_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass/fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/exec_branch.sv
verilog/exec_result_sel.sv
verilog/exec_stage_reg.sv
verilog/exec_stage.sv
dv/tb_exec_stage.sv

// File: dv/tb_exec_stage.sv
// Execute stage testbench
// Directed tests for ALU ops, branch resolve, jumps, load/store, CSR,
// traps, back-pressure, flush and reset values
`timescale 1ns/1ps
`include "exec_params.svh"

module tb_exec_stage import exec_pkg::*; ();

localparam int          DLY     = 10;       // Drive delay after rising edge
localparam int          TIMEOUT = 20;       // Cycles allowed per wait
localparam logic [31:0] SEED    = 32'h389e;

localparam logic [3:0] FU_ALU = 4'b1 << `EXEC_FU_ALU;
localparam logic [3:0] FU_LSU = 4'b1 << `EXEC_FU_LSU;
localparam logic [3:0] FU_CFU = 4'b1 << `EXEC_FU_CFU;
localparam logic [3:0] FU_CSR = 4'b1 << `EXEC_FU_CSR;
localparam logic [4:0] LSU_LW = (5'b1 << `EXEC_LSU_LOAD) | 5'b00010;   // Word load
localparam logic [4:0] LSU_SW = (5'b1 << `EXEC_LSU_STORE) | 5'b00010;  // Word store

logic                  g_clk;
logic                  g_resetn;
logic                  i_s2_valid;
logic [4:0]            i_s2_rd;
logic [`EXEC_XLEN-1:0] i_s2_opr_a;
logic [`EXEC_XLEN-1:0] i_s2_opr_b;
logic [`EXEC_XLEN-1:0] i_s2_opr_c;
uop_t                  i_s2_uop;
logic [`EXEC_FU_W-1:0] i_s2_fu;
logic                  i_s2_trap;
logic [1:0]            i_s2_size;
logic [31:0]           i_s2_instr;
logic                  i_flush;
logic                  o_s2_busy;
logic                  i_s3_busy;
logic                  o_s3_valid;
logic [4:0]            o_s3_rd;
logic [`EXEC_XLEN-1:0] o_s3_opr_a;
logic [`EXEC_XLEN-1:0] o_s3_opr_b;
uop_t                  o_s3_uop;
logic [`EXEC_FU_W-1:0] o_s3_fu;
logic                  o_s3_trap;
logic [1:0]            o_s3_size;
logic [31:0]           o_s3_instr;
logic [4:0]            o_fwd_rd;
logic [`EXEC_XLEN-1:0] o_fwd_wdata;
logic                  o_fwd_load;
logic                  o_fwd_csr;
logic [31:0]           lfsr;          // Operand generator state

exec_stage UUT (.*);

initial begin
    g_clk = 1'b0;
    forever #50 g_clk = !g_clk;   // 100 ns period
end

// Reporting and compare ---------------------------------------------------

task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on first error");
endtask

task automatic check_word(input string name, input logic [`EXEC_XLEN-1:0] got,
                          input logic [`EXEC_XLEN-1:0] exp);
    if (got !== exp)
        stop_with_error($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
endtask

task automatic check_uop(input string name, input uop_t got, input uop_t exp);
    if (got !== exp)
        stop_with_error($sformatf("[ERROR] %0t %s got %b expected %b",
                                  $time, name, got.code, exp.code));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
        stop_with_error($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
endtask

// Operand source ----------------------------------------------------------

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32,22,2,1
endfunction

task automatic rand_bits(input int n, output logic [31:0] w);
    w = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);      // One step per bit
        w    = {w[30:0], lfsr[0]};
    end
endtask

// Driver ------------------------------------------------------------------

task automatic drive_instr(input logic [3:0] fu, input logic [4:0] code,
                           input logic [31:0] a, b, c, input logic [4:0] rd,
                           input logic trap);
    logic [31:0] w;
    @(posedge g_clk);
    #DLY;
    i_s2_valid    = 1'b1;
    i_s2_fu       = fu;
    i_s2_uop.code = code;
    i_s2_opr_a    = a;
    i_s2_opr_b    = b;
    i_s2_opr_c    = c;
    i_s2_rd       = rd;
    i_s2_trap     = trap;
    rand_bits(2, w);
    i_s2_size     = w[1:0];
    rand_bits(32, i_s2_instr);
endtask

// Waits for acceptance, then for the result one cycle later
task automatic complete_instr();
    int n;
    n = 0;
    @(negedge g_clk);
    check_word("o_fwd_rd", 32'(o_fwd_rd), 32'(i_s2_rd));   // Seen while offered
    while (o_s2_busy) begin
        n++;
        if (n > TIMEOUT) stop_with_error("Timeout waiting for the stage to accept");
        @(negedge g_clk);
    end
    @(posedge g_clk);
    #DLY;
    i_s2_valid = 1'b0;
    n = 0;
    @(negedge g_clk);
    while (!o_s3_valid) begin
        n++;
        if (n > TIMEOUT) stop_with_error("Timeout waiting for o_s3_valid");
        @(negedge g_clk);
    end
    if (n != 0) stop_with_error($sformatf("Result arrived %0d cycles late", n));
    check_word("o_s3_rd", 32'(o_s3_rd), 32'(i_s2_rd));     // Fields copied as driven
    check_word("o_s3_fu", 32'(o_s3_fu), 32'(i_s2_fu));
    check_word("o_s3_size", 32'(o_s3_size), 32'(i_s2_size));
    check_word("o_s3_instr", o_s3_instr, i_s2_instr);
endtask

// Tests -------------------------------------------------------------------

task automatic test_alu();
    logic [4:0]  ops [10];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] exp;
    ops = '{`EXEC_ALU_ADD, `EXEC_ALU_SUB, `EXEC_ALU_XOR, `EXEC_ALU_OR, `EXEC_ALU_AND,
            `EXEC_ALU_SLL, `EXEC_ALU_SRL, `EXEC_ALU_SRA, `EXEC_ALU_SLT, `EXEC_ALU_SLTU};
    for (int i = 0; i < 10; i++) begin
        rand_bits(32, a);
        rand_bits(32, b);
        rand_bits(5, r);
        case (ops[i])
            `EXEC_ALU_ADD: exp = a + b;
            `EXEC_ALU_SUB: exp = a - b;
            `EXEC_ALU_XOR: exp = a ^ b;
            `EXEC_ALU_OR:  exp = a | b;
            `EXEC_ALU_AND: exp = a & b;
            `EXEC_ALU_SLL: exp = a << b[4:0];
            `EXEC_ALU_SRL: exp = a >> b[4:0];
            `EXEC_ALU_SRA: exp = ({32{a[31]}} << (32 - b[4:0])) | (a >> b[4:0]);  // Sign fill
            `EXEC_ALU_SLT: exp = {31'b0, $signed(a) < $signed(b)};
            default:       exp = {31'b0, a < b};
        endcase
        drive_instr(FU_ALU, ops[i], a, b, a, r[4:0], 1'b0);
        complete_instr();
        check_word("o_s3_opr_a", o_s3_opr_a, exp);
    end
endtask

task automatic test_branches();
    logic [4:0]  ops [6];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] x;
    logic        taken;
    uop_t        exp;
    ops = '{`EXEC_CFU_BEQ, `EXEC_CFU_BNE, `EXEC_CFU_BLT,
            `EXEC_CFU_BGE, `EXEC_CFU_BLTU, `EXEC_CFU_BGEU};
    for (int i = 0; i < 6; i++) begin
        for (int k = 0; k < 3; k++) begin
            rand_bits(32, x);
            rand_bits(32, c);
            a = x & 32'h7fff_ffff;                    // Positive
            b = (k == 0) ? a : a | 32'h8000_0000;     // Equal, or high bit set
            if (k == 2) begin
                x = a;   // Swap order
                a = b;
                b = x;
            end
            case (ops[i])
                `EXEC_CFU_BEQ:  taken = a == b;
                `EXEC_CFU_BNE:  taken = a != b;
                `EXEC_CFU_BLT:  taken = $signed(a) < $signed(b);
                `EXEC_CFU_BGE:  taken = $signed(a) >= $signed(b);
                `EXEC_CFU_BLTU: taken = a < b;
                default:        taken = a >= b;
            endcase
            exp.code = taken ? `EXEC_CFU_TAKEN : `EXEC_CFU_NOT_TAKEN;
            drive_instr(FU_CFU, ops[i], a, b, c, 5'd0, 1'b0);
            complete_instr();
            check_uop("o_s3_uop", o_s3_uop, exp);
            check_word("o_s3_opr_a", o_s3_opr_a, c & ~32'h1);
        end
    end
endtask

task automatic test_jumps();
    logic [4:0]  ops [3];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    uop_t        exp;
    ops = '{`EXEC_CFU_JMP, `EXEC_CFU_JALI, `EXEC_CFU_JALR};
    for (int i = 0; i < 3; i++) begin
        rand_bits(32, a);
        rand_bits(32, b);
        rand_bits(32, c);
        exp.code = ops[i];   // Jumps keep their code
        drive_instr(FU_CFU, ops[i], a, b, c, 5'd1, 1'b0);
        complete_instr();
        check_uop("o_s3_uop", o_s3_uop, exp);
        check_word("o_s3_opr_a", o_s3_opr_a,
                   (ops[i] == `EXEC_CFU_JALR) ? (a + b) & ~32'h1 : c & ~32'h1);
    end
endtask

task automatic test_load_store();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] sdata;
    rand_bits(32, a);
    rand_bits(32, b);
    rand_bits(32, c);
    drive_instr(FU_LSU, LSU_SW, a, b, c, 5'd0, 1'b0);
    #1;
    check_bit("o_fwd_load", o_fwd_load, 1'b0);
    complete_instr();
    check_word("o_s3_opr_a", o_s3_opr_a, a + b);
    check_word("o_s3_opr_b", o_s3_opr_b, c);        // Store data
    sdata = c;
    rand_bits(32, a);
    rand_bits(32, c);
    drive_instr(FU_LSU, LSU_LW, a, b, c, 5'd7, 1'b0);
    #1;
    check_bit("o_fwd_load", o_fwd_load, 1'b1);     // Seen while offered
    check_word("o_fwd_wdata", o_fwd_wdata, a + b);
    complete_instr();
    check_word("o_s3_opr_a", o_s3_opr_a, a + b);
    check_word("o_s3_opr_b", o_s3_opr_b, sdata);    // Loads leave operand B alone
endtask

task automatic test_csr_trap();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] r;
    rand_bits(32, a);
    rand_bits(32, b);
    rand_bits(32, c);
    drive_instr(FU_CSR, 5'b00001, a, b, c, 5'd3, 1'b0);
    #1;
    check_bit("o_fwd_csr", o_fwd_csr, 1'b1);
    complete_instr();
    check_word("o_s3_opr_a", o_s3_opr_a, a);
    check_word("o_s3_opr_b", o_s3_opr_b, c);
    rand_bits(5, r);
    drive_instr(FU_ALU, `EXEC_ALU_ADD, a, b, c, r[4:0], 1'b1);
    complete_instr();
    check_bit("o_s3_trap", o_s3_trap, 1'b1);
    check_word("o_s3_opr_b", o_s3_opr_b, 32'(r[4:0]));   // Cause from rd
endtask

task automatic test_backpressure();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] held_a;
    uop_t        held_uop;
    rand_bits(32, a);
    rand_bits(32, b);
    drive_instr(FU_ALU, `EXEC_ALU_ADD, a, b, a, 5'd1, 1'b0);
    i_s3_busy = 1'b1;
    complete_instr();
    check_word("o_s3_opr_a", o_s3_opr_a, a + b);
    held_a   = o_s3_opr_a;
    held_uop = o_s3_uop;
    rand_bits(32, a);
    rand_bits(32, b);
    drive_instr(FU_ALU, `EXEC_ALU_XOR, a, b, a, 5'd2, 1'b0);
    repeat (4) begin
        @(negedge g_clk);
        check_bit("o_s2_busy", o_s2_busy, 1'b1);
        check_bit("o_s3_valid", o_s3_valid, 1'b1);
        check_word("o_s3_opr_a", o_s3_opr_a, held_a);
        check_uop("o_s3_uop", o_s3_uop, held_uop);
    end
    @(posedge g_clk);
    #DLY;
    i_s3_busy = 1'b0;
    complete_instr();
    check_word("o_s3_opr_a", o_s3_opr_a, a ^ b);
endtask

task automatic test_flush();
    logic [31:0] a;
    logic [31:0] b;
    rand_bits(32, a);
    rand_bits(32, b);
    drive_instr(FU_ALU, `EXEC_ALU_ADD, a, b, a, 5'd3, 1'b0);
    i_s3_busy = 1'b1;       // Park it in stage 3
    complete_instr();
    @(posedge g_clk);
    #DLY;
    i_flush = 1'b1;         // Stalled entry must still be killed
    @(posedge g_clk);
    #DLY;
    check_bit("o_s3_valid", o_s3_valid, 1'b0);
    check_bit("o_s2_busy", o_s2_busy, 1'b0);
    drive_instr(FU_ALU, `EXEC_ALU_SUB, b, a, a, 5'd4, 1'b0);
    i_s3_busy = 1'b0;       // Only the flush blocks acceptance
    @(posedge g_clk);
    #DLY;
    check_bit("o_s3_valid", o_s3_valid, 1'b0);
    check_bit("o_s2_busy", o_s2_busy, 1'b0);
    i_s2_valid = 1'b0;
    i_flush    = 1'b0;
    @(negedge g_clk);
    check_bit("o_s3_valid", o_s3_valid, 1'b0);
endtask

initial begin
    lfsr       = SEED;
    g_resetn   = 1'b0;
    i_s2_valid = 1'b0;
    i_s2_rd    = '0;
    i_s2_opr_a = '0;
    i_s2_opr_b = '0;
    i_s2_opr_c = '0;
    i_s2_uop   = '0;
    i_s2_fu    = '0;
    i_s2_trap  = 1'b0;
    i_s2_size  = '0;
    i_s2_instr = '0;
    i_flush    = 1'b0;
    i_s3_busy  = 1'b1;      // Busy must not leak through reset
    repeat (9) @(posedge g_clk);
    @(negedge g_clk);
    check_bit("o_s3_valid", o_s3_valid, 1'b0);
    check_bit("o_s2_busy", o_s2_busy, 1'b0);
    @(posedge g_clk);
    #DLY;
    g_resetn  = 1'b1;
    i_s3_busy = 1'b0;
    test_alu();
    test_branches();
    test_jumps();
    test_load_store();
    test_csr_trap();
    test_backpressure();
    test_flush();
    $display(">>> PASS");
    $finish;
end

endmodule

// File: verilog/exec_alu.sv
// Integer ALU
// Add/sub, logic ops, barrel shifts and signed/unsigned compare,
// also provides the compare flags and raw sum used by branches and the LSU
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_alu import exec_pkg::*; (
    input  logic [`EXEC_FU_W-1:0] i_fu,          // Functional unit, one-hot
    input  uop_t                  i_uop,         // Micro-op
    input  logic [`EXEC_XLEN-1:0] i_lhs,         // Left operand
    input  logic [`EXEC_XLEN-1:0] i_rhs,         // Right operand
    output logic [`EXEC_XLEN-1:0] o_result,      // Selected result
    output logic [`EXEC_XLEN-1:0] o_add_result,  // Always lhs + rhs
    output logic                  o_lt,          // lhs < rhs
    output logic                  o_eq           // lhs == rhs
);

logic                  fu_alu;        // ALU op in flight
logic                  fu_cfu;        // Branch using our compare
logic                  cmp_unsigned;  // Unsigned compare select
logic                  cfu_unsigned;  // BLTU / BGEU
logic [4:0]            shamt;         // Shift amount
logic [`EXEC_XLEN-1:0] sub_result;

assign fu_alu = i_fu[`EXEC_FU_ALU];
assign fu_cfu = i_fu[`EXEC_FU_CFU];

// Unsigned branches decoded through the cfu view
assign cfu_unsigned = fu_cfu && i_uop.cfu.cls == 2'b00 &&
                      (i_uop.code == `EXEC_CFU_BLTU || i_uop.code == `EXEC_CFU_BGEU);

assign cmp_unsigned = (fu_alu && i_uop.code == `EXEC_ALU_SLTU) || cfu_unsigned;

// Adder and comparator ----------------------------------------------------

assign o_add_result = i_lhs + i_rhs;
assign sub_result   = i_lhs - i_rhs;
assign o_eq         = i_lhs == i_rhs;
assign o_lt         = cmp_unsigned ? (i_lhs < i_rhs) :           // Unsigned
                                     ($signed(i_lhs) < $signed(i_rhs));

assign shamt = i_rhs[4:0];  // RV32 takes low 5 bits

// Result select ------------------------------------------------------------

always_comb begin
    case (i_uop.code)
        `EXEC_ALU_ADD:  o_result = o_add_result;
        `EXEC_ALU_SUB:  o_result = sub_result;
        `EXEC_ALU_XOR:  o_result = i_lhs ^ i_rhs;
        `EXEC_ALU_OR:   o_result = i_lhs | i_rhs;
        `EXEC_ALU_AND:  o_result = i_lhs & i_rhs;
        `EXEC_ALU_SLL:  o_result = i_lhs << shamt;
        `EXEC_ALU_SRL:  o_result = i_lhs >> shamt;
        `EXEC_ALU_SRA:  o_result = $unsigned($signed(i_lhs) >>> shamt);  // Sign fill
        `EXEC_ALU_SLT,
        `EXEC_ALU_SLTU: o_result = {{(`EXEC_XLEN-1){1'b0}}, o_lt};   // 0 or 1
        default:        o_result = '0;
    endcase
end

endmodule

// File: verilog/exec_branch.sv
// Branch unit
// Resolves the six compare conditions into a TAKEN / NOT_TAKEN micro-op
// and forms the jump or branch target
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_branch import exec_pkg::*; (
    input  logic [`EXEC_FU_W-1:0] i_fu,          // Functional unit, one-hot
    input  uop_t                  i_uop,         // Incoming micro-op
    input  logic [`EXEC_XLEN-1:0] i_add_result,  // rs1 + imm for JALR
    input  logic [`EXEC_XLEN-1:0] i_opr_c,       // Precomputed PC target
    input  logic                  i_lt,          // Compare flags from ALU
    input  logic                  i_eq,
    output uop_t                  o_uop,         // Rewritten micro-op
    output logic [`EXEC_XLEN-1:0] o_target       // Jump / branch target
);

logic cond;   // Conditional branch
logic taken;  // Condition holds
logic jalr;

assign cond = i_fu[`EXEC_FU_CFU] && i_uop.cfu.cls == 2'b00;
assign jalr = i_fu[`EXEC_FU_CFU] && i_uop.code == `EXEC_CFU_JALR;

// Signedness already chosen in the ALU compare
always_comb begin
    case (i_uop.code)
        `EXEC_CFU_BEQ:  taken = i_eq;
        `EXEC_CFU_BNE:  taken = !i_eq;
        `EXEC_CFU_BLT,
        `EXEC_CFU_BLTU: taken = i_lt;
        `EXEC_CFU_BGE,
        `EXEC_CFU_BGEU: taken = !i_lt;
        default:        taken = 1'b0;
    endcase
end

always_comb begin
    o_uop = i_uop;  // Non-branches pass through
    if (cond) begin
        o_uop.code = taken ? `EXEC_CFU_TAKEN : `EXEC_CFU_NOT_TAKEN;
    end
end

// Bit 0 always cleared
assign o_target = jalr ? {i_add_result[`EXEC_XLEN-1:1], 1'b0} :
                         {i_opr_c[`EXEC_XLEN-1:1], 1'b0};

endmodule

// File: verilog/exec_params.svh
// Execute stage constants
// Widths, functional-unit bit positions and micro-op encodings
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

`define EXEC_XLEN      32        // Data word width
`define EXEC_UOP_W     5         // Micro-op width
`define EXEC_CAUSE_W   6         // Trap cause width

// Functional unit one-hot positions ---------------------------------------
`define EXEC_FU_W      4
`define EXEC_FU_ALU    0
`define EXEC_FU_LSU    1
`define EXEC_FU_CFU    2
`define EXEC_FU_CSR    3

// ALU micro-ops ------------------------------------------------------------
`define EXEC_ALU_ADD   5'b00001
`define EXEC_ALU_SUB   5'b00010
`define EXEC_ALU_XOR   5'b00011
`define EXEC_ALU_OR    5'b00100
`define EXEC_ALU_AND   5'b00101
`define EXEC_ALU_SLL   5'b00110
`define EXEC_ALU_SRL   5'b00111
`define EXEC_ALU_SRA   5'b01000
`define EXEC_ALU_SLT   5'b01001
`define EXEC_ALU_SLTU  5'b01010

// CFU micro-ops, class in bits 4:3 -----------------------------------------
`define EXEC_CFU_BEQ       5'b00001   // Class 00, conditional
`define EXEC_CFU_BGE       5'b00010
`define EXEC_CFU_BGEU      5'b00011
`define EXEC_CFU_BLT       5'b00100
`define EXEC_CFU_BLTU      5'b00101
`define EXEC_CFU_BNE       5'b00110
`define EXEC_CFU_JMP       5'b10001   // Class 10, unconditional
`define EXEC_CFU_JALI      5'b10010
`define EXEC_CFU_JALR      5'b10100
`define EXEC_CFU_TAKEN     5'b01001   // Rewritten branch outcomes
`define EXEC_CFU_NOT_TAKEN 5'b01000

// LSU micro-op flag bits
`define EXEC_LSU_LOAD  3
`define EXEC_LSU_STORE 4

`endif

// File: verilog/exec_pkg.sv
// Execute stage package
// Micro-op word with its three decode views
package exec_pkg;

`include "exec_params.svh"

    // Load/store view, flags sit at EXEC_LSU_STORE and EXEC_LSU_LOAD
    typedef struct packed {
        logic                   store;  // Bit 4
        logic                   load;   // Bit 3
        logic [`EXEC_UOP_W-3:0] width;  // Access width code
    } uop_lsu_t;

    // Control-flow view
    typedef struct packed {
        logic [1:0]             cls;    // 00 cond, 10 jump, 01 outcome
        logic [2:0]             cond;   // Condition / jump kind
    } uop_cfu_t;

    // One micro-op word, decoded per functional unit
    typedef union packed {
        logic [`EXEC_UOP_W-1:0] code;   // ALU and CSR
        uop_lsu_t               lsu;
        uop_cfu_t               cfu;
    } uop_t;

endpackage

// File: verilog/exec_result_sel.sv
// Result select
// Picks the two stage-3 operands per functional unit, folds in the
// trap cause and drives the forwarding flags
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_result_sel import exec_pkg::*; (
    input  logic [`EXEC_FU_W-1:0] i_fu,          // Functional unit, one-hot
    input  uop_t                  i_uop,         // Micro-op
    input  logic                  i_trap,        // Raise a trap
    input  logic [4:0]            i_rd,          // Dest reg, or cause on trap
    input  logic [`EXEC_XLEN-1:0] i_alu_result,
    input  logic [`EXEC_XLEN-1:0] i_add_result,  // Address sum
    input  logic [`EXEC_XLEN-1:0] i_target,      // CFU target
    input  logic [`EXEC_XLEN-1:0] i_opr_a,
    input  logic [`EXEC_XLEN-1:0] i_opr_c,
    output logic [`EXEC_XLEN-1:0] o_opr_a,       // Next stage-3 operand A
    output logic [`EXEC_XLEN-1:0] o_opr_b,       // Next stage-3 operand B
    output logic                  o_opr_b_ld,    // Operand B load enable
    output logic                  o_fwd_load,    // Load in stage 2
    output logic                  o_fwd_csr      // CSR op in stage 2
);

logic                     fu_alu;
logic                     fu_lsu;
logic                     fu_cfu;
logic                     fu_csr;
logic                     lsu_store;
logic [`EXEC_CAUSE_W-1:0] trap_cause;

assign fu_alu = i_fu[`EXEC_FU_ALU];
assign fu_lsu = i_fu[`EXEC_FU_LSU];
assign fu_cfu = i_fu[`EXEC_FU_CFU];
assign fu_csr = i_fu[`EXEC_FU_CSR];

assign lsu_store  = fu_lsu && i_uop.lsu.store;
assign trap_cause = {1'b0, i_rd};  // Decode packs cause in rd

// One-hot AND-OR mux
assign o_opr_a = {`EXEC_XLEN{fu_alu}} & i_alu_result |
                 {`EXEC_XLEN{fu_lsu}} & i_add_result |
                 {`EXEC_XLEN{fu_cfu}} & i_target     |
                 {`EXEC_XLEN{fu_csr}} & i_opr_a;

assign o_opr_b = i_trap                ? {{(`EXEC_XLEN-`EXEC_CAUSE_W){1'b0}}, trap_cause} :
                 (lsu_store || fu_csr) ? i_opr_c :                  // Store data / CSR
                                         '0;

assign o_opr_b_ld = lsu_store || fu_csr || i_trap;

assign o_fwd_load = fu_lsu && i_uop.lsu.load;
assign o_fwd_csr  = fu_csr;

endmodule

// File: verilog/exec_stage.sv
// Execute stage top level
// ALU, branch resolve and result select feeding one pipeline register
// toward writeback, plus stage-2 forwarding outputs
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_stage import exec_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_s2_valid,   // Decode offers instruction
    input  logic [4:0]            i_s2_rd,
    input  logic [`EXEC_XLEN-1:0] i_s2_opr_a,
    input  logic [`EXEC_XLEN-1:0] i_s2_opr_b,
    input  logic [`EXEC_XLEN-1:0] i_s2_opr_c,
    input  uop_t                  i_s2_uop,
    input  logic [`EXEC_FU_W-1:0] i_s2_fu,
    input  logic                  i_s2_trap,
    input  logic [1:0]            i_s2_size,
    input  logic [31:0]           i_s2_instr,
    input  logic                  i_flush,
    output logic                  o_s2_busy,    // Stall decode
    input  logic                  i_s3_busy,    // Writeback stall
    output logic                  o_s3_valid,
    output logic [4:0]            o_s3_rd,
    output logic [`EXEC_XLEN-1:0] o_s3_opr_a,
    output logic [`EXEC_XLEN-1:0] o_s3_opr_b,
    output uop_t                  o_s3_uop,
    output logic [`EXEC_FU_W-1:0] o_s3_fu,
    output logic                  o_s3_trap,
    output logic [1:0]            o_s3_size,
    output logic [31:0]           o_s3_instr,
    output logic [4:0]            o_fwd_rd,     // Forwarding from stage 2
    output logic [`EXEC_XLEN-1:0] o_fwd_wdata,
    output logic                  o_fwd_load,
    output logic                  o_fwd_csr
);

logic [`EXEC_XLEN-1:0] alu_result;
logic [`EXEC_XLEN-1:0] add_result;
logic                  alu_lt;
logic                  alu_eq;
uop_t                  n_uop;       // After branch rewrite
logic [`EXEC_XLEN-1:0] cfu_target;
logic [`EXEC_XLEN-1:0] n_opr_a;
logic [`EXEC_XLEN-1:0] n_opr_b;
logic                  n_opr_b_ld;

assign o_fwd_rd    = i_s2_rd;
assign o_fwd_wdata = n_opr_a;

// Functional units ---------------------------------------------------------

exec_alu u_alu (
    .i_fu         (i_s2_fu),
    .i_uop        (i_s2_uop),
    .i_lhs        (i_s2_opr_a),
    .i_rhs        (i_s2_opr_b),
    .o_result     (alu_result),
    .o_add_result (add_result),
    .o_lt         (alu_lt),
    .o_eq         (alu_eq)
);

exec_branch u_branch (
    .i_fu         (i_s2_fu),
    .i_uop        (i_s2_uop),
    .i_add_result (add_result),
    .i_opr_c      (i_s2_opr_c),
    .i_lt         (alu_lt),
    .i_eq         (alu_eq),
    .o_uop        (n_uop),
    .o_target     (cfu_target)
);

exec_result_sel u_result_sel (
    .i_fu         (i_s2_fu),
    .i_uop        (i_s2_uop),
    .i_trap       (i_s2_trap),
    .i_rd         (i_s2_rd),
    .i_alu_result (alu_result),
    .i_add_result (add_result),
    .i_target     (cfu_target),
    .i_opr_a      (i_s2_opr_a),
    .i_opr_c      (i_s2_opr_c),
    .o_opr_a      (n_opr_a),
    .o_opr_b      (n_opr_b),
    .o_opr_b_ld   (n_opr_b_ld),
    .o_fwd_load   (o_fwd_load),
    .o_fwd_csr    (o_fwd_csr)
);

// Pipeline register --------------------------------------------------------

exec_stage_reg u_stage_reg (
    .g_clk      (g_clk),
    .g_resetn   (g_resetn),
    .i_valid    (i_s2_valid),
    .i_flush    (i_flush),
    .i_busy     (i_s3_busy),
    .i_opr_b_ld (n_opr_b_ld),
    .i_rd       (i_s2_rd),
    .i_uop      (n_uop),
    .i_fu       (i_s2_fu),
    .i_trap     (i_s2_trap),
    .i_size     (i_s2_size),
    .i_instr    (i_s2_instr),
    .i_opr_a    (n_opr_a),
    .i_opr_b    (n_opr_b),
    .o_busy     (o_s2_busy),
    .o_valid    (o_s3_valid),
    .o_rd       (o_s3_rd),
    .o_uop      (o_s3_uop),
    .o_fu       (o_s3_fu),
    .o_trap     (o_s3_trap),
    .o_size     (o_s3_size),
    .o_instr    (o_s3_instr),
    .o_opr_a    (o_s3_opr_a),
    .o_opr_b    (o_s3_opr_b)
);

endmodule

// File: verilog/exec_stage_reg.sv
// Execute to writeback pipeline register
// Single entry with valid/busy levels and flush, operand B loads on demand
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_stage_reg (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   i_valid,     // Stage-2 offer
    input  logic                   i_flush,     // Kill stage contents
    input  logic                   i_busy,      // Writeback stalled
    input  logic                   i_opr_b_ld,  // Operand B load enable
    input  logic [4:0]             i_rd,
    input  logic [`EXEC_UOP_W-1:0] i_uop,
    input  logic [`EXEC_FU_W-1:0]  i_fu,
    input  logic                   i_trap,
    input  logic [1:0]             i_size,
    input  logic [31:0]            i_instr,
    input  logic [`EXEC_XLEN-1:0]  i_opr_a,
    input  logic [`EXEC_XLEN-1:0]  i_opr_b,
    output logic                   o_busy,      // Back-pressure to stage 2
    output logic                   o_valid,
    output logic [4:0]             o_rd,
    output logic [`EXEC_UOP_W-1:0] o_uop,
    output logic [`EXEC_FU_W-1:0]  o_fu,
    output logic                   o_trap,
    output logic [1:0]             o_size,
    output logic [31:0]            o_instr,
    output logic [`EXEC_XLEN-1:0]  o_opr_a,
    output logic [`EXEC_XLEN-1:0]  o_opr_b
);

logic accept;  // Instruction taken this edge

assign o_busy = o_valid && i_busy;
assign accept = i_valid && !o_busy && !i_flush;

always_ff @(posedge g_clk) begin
    if (!g_resetn || i_flush) begin
        o_valid <= 1'b0;
    end else if (accept) begin
        o_valid <= 1'b1;
    end else if (!i_busy) begin
        o_valid <= 1'b0;  // Drained, nothing new
    end
end

// Payload ------------------------------------------------------------------

always_ff @(posedge g_clk) begin
    if (accept) begin
        o_rd    <= i_rd;
        o_uop   <= i_uop;
        o_fu    <= i_fu;
        o_trap  <= i_trap;
        o_size  <= i_size;
        o_instr <= i_instr;
        o_opr_a <= i_opr_a;
    end
    if (accept && i_opr_b_ld) begin
        o_opr_b <= i_opr_b;  // Otherwise keeps old value
    end
end

endmodule
